//--- cache_l1.f
src/cache_pkg.sv
src/cache_tag_store.sv
src/cache_meta_store.sv
src/cache_data_store.sv
src/cache_stage_ctrl.sv
src/cache_stage_top.sv
verif/cache_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build the cache stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cache_stage_tb \
    -f cache_l1.f -o cache_stage_sim &&
    ./obj_dir/cache_stage_sim | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null ||
    { echo "cache stage simulation failed"; exit 1; }
echo "cache stage simulation passed"

//--- verif/cache_stage_tb.sv
`timescale 1ns/1ps

module cache_stage_tb
    import cache_pkg::*;
();

    localparam int op_idle      = 0;
    localparam int op_read      = 1;
    localparam int op_write     = 2;
    localparam int op_fill      = 3;
    localparam int op_credit    = 4;
    localparam int op_fill_read = 5;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    logic                  req_write;
    logic [addr_bits-1:0]  req_addr;
    logic [line_bits-1:0]  req_data;
    logic [line_bytes-1:0] req_mask;
    logic                  fill_valid;
    logic [addr_bits-1:0]  fill_addr;
    logic [line_bits-1:0]  fill_line;
    logic                  credit_return;
    logic                  req_ready, resp_valid, resp_hit, miss_valid, wb_valid;
    logic [line_bits-1:0]  resp_line, wb_line;
    logic [addr_bits-1:0]  miss_addr, wb_addr;

    // Reference copy of the cache state
    logic [tag_bits-1:0]  m_tag   [num_sets][num_ways];
    logic                 m_valid [num_sets][num_ways];
    logic                 m_dirty [num_sets][num_ways];
    logic [line_bits-1:0] m_line  [num_sets][num_ways];
    int                   m_age   [num_sets][num_ways];
    int                   m_credits;

    // Outputs expected one cycle after the current row
    logic                 exp_ready, exp_resp, exp_hit, exp_miss, exp_wb;
    logic [line_bits-1:0] exp_line, exp_wb_line;
    logic [addr_bits-1:0] exp_miss_addr, exp_wb_addr;

    int                    row_op   [$];
    logic [addr_bits-1:0]  row_addr [$];
    logic [line_bytes-1:0] row_mask [$];
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycle_limit = 1000;

    cache_stage_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Rows use a nonzero offset so the miss address must clear it
    task automatic add_row(input int op, input logic [tag_bits-1:0] tag,
            input logic [index_bits-1:0] idx, input logic [line_bytes-1:0] mask);
        row_op.push_back(op);
        row_addr.push_back({tag, idx, 5'h0b});
        row_mask.push_back(mask);
    endtask

    task automatic check_value(input string name, input logic [line_bits-1:0] expected,
            input logic [line_bits-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %0h actual %0h",
                $time, name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        check_value("resp_valid", exp_resp, resp_valid);
        if (exp_resp)
            check_value("resp_hit", exp_hit, resp_hit);
        if (exp_hit)
            check_value("resp_line", exp_line, resp_line);
        check_value("miss_valid", exp_miss, miss_valid);
        if (exp_miss)
            check_value("miss_addr", exp_miss_addr, miss_addr);
        check_value("wb_valid", exp_wb, wb_valid);
        if (exp_wb) begin
            check_value("wb_addr", exp_wb_addr, wb_addr);
            check_value("wb_line", exp_wb_line, wb_line);
        end
    endtask

    // Touched way becomes newest, ways newer than it age by one
    task automatic touch_way(input logic [index_bits-1:0] idx, input int way);
        int old_age;
        old_age = m_age[idx][way];
        for (int w = 0; w < num_ways; w++) begin
            if (w == way)
                m_age[idx][w] = 0;
            else if (m_age[idx][w] < old_age)
                m_age[idx][w]++;
        end
    endtask

    task automatic model_step(input int op, input logic [addr_bits-1:0] addr,
            input logic [line_bytes-1:0] mask);
        logic [index_bits-1:0] idx;
        int way;
        idx = addr[6:5];
        way = -1;
        {exp_ready, exp_resp, exp_hit, exp_miss, exp_wb} = '0;
        if (op == op_fill || op == op_fill_read) begin
            // Oldest way unless some way is still invalid
            for (int w = 0; w < num_ways; w++) begin
                if (m_age[idx][w] == num_ways - 1)
                    way = w;
            end
            for (int w = num_ways - 1; w >= 0; w--) begin
                if (!m_valid[idx][w])
                    way = w;
            end
            exp_wb = m_valid[idx][way] && m_dirty[idx][way];
            exp_wb_addr = {m_tag[idx][way], idx, 5'b0};
            exp_wb_line = m_line[idx][way];
            m_tag[idx][way] = addr[14:7];
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
            m_line[idx][way] = fill_line;
            touch_way(idx, way);
        end else if (op == op_read || op == op_write) begin
            for (int w = 0; w < num_ways; w++) begin
                if (m_valid[idx][w] && m_tag[idx][w] == addr[14:7])
                    way = w;
            end
            exp_ready = way >= 0 || m_credits > 0;
            exp_resp = exp_ready;
            exp_hit = way >= 0;
            exp_miss = exp_ready && way < 0;
            exp_miss_addr = {addr[14:5], 5'b0};
            if (exp_miss)
                m_credits--;
            if (exp_hit) begin
                for (int b = 0; b < line_bytes; b++) begin
                    if (op == op_write && mask[b])
                        m_line[idx][way][b*8 +: 8] = req_data[b*8 +: 8];
                end
                if (op == op_write)
                    m_dirty[idx][way] = 1'b1;
                exp_line = m_line[idx][way];
                touch_way(idx, way);
            end
        end else if (op == op_credit) begin
            m_credits++;
        end
    endtask

    initial begin
        void'($urandom(8));
        {req_valid, req_write, fill_valid, credit_return} = '0;
        req_addr = '0;
        req_data = '0;
        req_mask = '0;
        fill_addr = '0;
        fill_line = '0;
        reset = 1'b1;
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w] = w;
            end
        end
        m_credits = miss_credits;
        {exp_ready, exp_resp, exp_hit, exp_miss, exp_wb} = '0;

        // Cold miss, fill, hit, masked write
        add_row(op_read, 8'h12, 2'd0, '0);
        add_row(op_credit, 8'h00, 2'd0, '0);
        add_row(op_fill, 8'h12, 2'd0, '0);
        add_row(op_read, 8'h12, 2'd0, '0);
        add_row(op_write, 8'h12, 2'd0, 16'h00f0);
        add_row(op_read, 8'h12, 2'd0, '0);
        // Six lines into set 1, dirty then clean victim
        add_row(op_fill, 8'h20, 2'd1, '0);
        add_row(op_write, 8'h20, 2'd1, '0);
        add_row(op_fill, 8'h21, 2'd1, '0);
        add_row(op_fill, 8'h22, 2'd1, '0);
        add_row(op_fill, 8'h23, 2'd1, '0);
        add_row(op_fill, 8'h24, 2'd1, '0);
        add_row(op_fill, 8'h25, 2'd1, '0);
        // Credits run out, hits still pass
        add_row(op_read, 8'h20, 2'd1, '0);
        add_row(op_read, 8'h30, 2'd2, '0);
        add_row(op_read, 8'h31, 2'd2, '0);
        add_row(op_read, 8'h25, 2'd1, '0);
        add_row(op_credit, 8'h00, 2'd0, '0);
        add_row(op_read, 8'h31, 2'd2, '0);
        add_row(op_credit, 8'h00, 2'd0, '0);
        add_row(op_credit, 8'h00, 2'd0, '0);
        // Fill wins over a request in the same cycle
        add_row(op_fill_read, 8'h31, 2'd2, '0);
        add_row(op_read, 8'h31, 2'd2, '0);
        add_row(op_read, 8'h24, 2'd1, '0);
        add_row(op_idle, 8'h00, 2'd0, '0);
        cycle_limit = row_op.size() * 4 + 50;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_outputs();
        foreach (row_op[i]) begin
            req_valid = row_op[i] inside {op_read, op_write, op_fill_read};
            req_write = row_op[i] == op_write;
            fill_valid = row_op[i] inside {op_fill, op_fill_read};
            // An unused address port points at some other line
            req_addr = req_valid || !fill_valid ? row_addr[i] : ~row_addr[i];
            fill_addr = fill_valid ? row_addr[i] : ~row_addr[i];
            req_data = {$urandom, $urandom, $urandom, $urandom};
            req_mask = row_mask[i] != '0 ? row_mask[i] : line_bytes'($urandom);
            fill_line = {$urandom, $urandom, $urandom, $urandom};
            credit_return = row_op[i] == op_credit;
            #2;
            model_step(row_op[i], row_addr[i], req_mask);
            if (req_valid)
                check_value("req_ready", exp_ready, req_ready);
            @(negedge clk);
            check_outputs();
        end

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- src/cache_stage_top.sv
`timescale 1ns/1ps

module cache_stage_top
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  logic [addr_bits-1:0]  req_addr,
    input  logic                  req_write,
    input  logic [line_bits-1:0]  req_data,
    input  logic [line_bytes-1:0] req_mask,
    input  logic                  fill_valid,
    input  logic [addr_bits-1:0]  fill_addr,
    input  logic [line_bits-1:0]  fill_line,
    input  logic                  credit_return,
    output logic                  req_ready,
    output logic                  resp_valid,
    output logic                  resp_hit,
    output logic [line_bits-1:0]  resp_line,
    output logic                  miss_valid,
    output logic [addr_bits-1:0]  miss_addr,
    output logic                  wb_valid,
    output logic [addr_bits-1:0]  wb_addr,
    output logic [line_bits-1:0]  wb_line
);

    phys_addr_t           look_addr;
    hit_vec_t             hit_vec;
    logic [num_ways-1:0]  valid_vec;
    way_t                 hit_way;
    way_t                 victim_way;
    logic                 victim_dirty;
    logic [tag_bits-1:0]  victim_tag;
    logic [line_bits-1:0] read_line;
    logic [line_bits-1:0] victim_line;
    logic                 data_we;
    logic                 touch;
    logic                 fill_we;

    cache_stage_ctrl u_ctrl (
        .clk, .reset, .req_valid, .req_addr, .req_write, .fill_valid, .fill_addr,
        .credit_return, .hit_vec, .victim_way, .victim_dirty, .victim_tag, .read_line,
        .victim_line, .req_ready, .look_addr, .data_we, .tag_we(touch), .fill_we, .hit_way,
        .resp_valid, .resp_hit, .resp_line, .miss_valid, .miss_addr, .wb_valid, .wb_addr,
        .wb_line
    );

    cache_tag_store u_tags (
        .clk, .reset, .look_addr, .fill_we, .victim_way, .hit_vec, .victim_tag, .valid_vec
    );

    cache_meta_store u_meta (
        .clk, .reset, .look_addr, .valid_vec, .touch, .hit_way, .data_we, .fill_we,
        .victim_way, .victim_dirty
    );

    cache_data_store u_data (
        .clk, .reset, .look_addr, .hit_way, .victim_way, .data_we, .fill_we, .req_data,
        .req_mask, .fill_line, .read_line, .victim_line
    );

endmodule

//--- src/cache_stage_ctrl.sv
`timescale 1ns/1ps

module cache_stage_ctrl
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  logic [addr_bits-1:0] req_addr,
    input  logic                 req_write,
    input  logic                 fill_valid,
    input  logic [addr_bits-1:0] fill_addr,
    input  logic                 credit_return,
    input  hit_vec_t             hit_vec,
    input  way_t                 victim_way,
    input  logic                 victim_dirty,
    input  logic [tag_bits-1:0]  victim_tag,
    input  logic [line_bits-1:0] read_line,
    input  logic [line_bits-1:0] victim_line,
    output logic                 req_ready,
    output phys_addr_t           look_addr,
    output logic                 data_we,
    output logic                 tag_we,
    output logic                 fill_we,
    output way_t                 hit_way,
    output logic                 resp_valid,
    output logic                 resp_hit,
    output logic [line_bits-1:0] resp_line,
    output logic                 miss_valid,
    output logic [addr_bits-1:0] miss_addr,
    output logic                 wb_valid,
    output logic [addr_bits-1:0] wb_addr,
    output logic [line_bits-1:0] wb_line
);

    logic [credit_bits-1:0] credit_cnt;
    logic                   lookup_hit;
    logic                   credit_free;
    logic                   accept;
    way_t                   enc_way;

    // Fill owns the lookup port
    assign look_addr.raw = fill_valid ? fill_addr : req_addr;
    assign lookup_hit = |hit_vec;

    // The miss in the response register still holds its credit
    assign credit_free = credit_cnt > credit_bits'(miss_valid);
    assign req_ready = !fill_valid && (lookup_hit || credit_free);
    assign accept = req_valid && req_ready;

    assign fill_we = fill_valid;
    assign data_we = accept && req_write && lookup_hit;
    // LRU touch on a hit or a fill
    assign tag_we = fill_valid || (accept && lookup_hit);

    always_comb begin
        enc_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_vec[w]) begin
                enc_way = way_t'(w);
            end
        end
    end

    assign hit_way = fill_valid ? victim_way : enc_way;

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
            miss_valid <= 1'b0;
            wb_valid   <= 1'b0;
            credit_cnt <= credit_bits'(miss_credits);
        end else begin
            resp_valid <= accept;
            miss_valid <= accept && !lookup_hit;
            wb_valid   <= fill_valid && victim_dirty;
            credit_cnt <= credit_cnt - credit_bits'(miss_valid) + credit_bits'(credit_return);
        end
    end

    always_ff @(posedge clk) begin
        resp_hit  <= lookup_hit;
        resp_line <= read_line;
        miss_addr <= {look_addr.f.tag, look_addr.f.index, {offset_bits{1'b0}}};
        wb_addr   <= {victim_tag, look_addr.f.index, {offset_bits{1'b0}}};
        wb_line   <= victim_line;
    end

    a_miss_credit: assert property (@(posedge clk) disable iff (reset)
        miss_valid |-> credit_cnt != '0);
    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= credit_bits'(miss_credits));
    a_hit_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(hit_vec));

endmodule

//--- src/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  phys_addr_t            look_addr,
    input  way_t                  hit_way,
    input  way_t                  victim_way,
    input  logic                  data_we,
    input  logic                  fill_we,
    input  logic [line_bits-1:0]  req_data,
    input  logic [line_bytes-1:0] req_mask,
    input  logic [line_bits-1:0]  fill_line,
    output logic [line_bits-1:0]  read_line,
    output logic [line_bits-1:0]  victim_line
);

    logic [line_bits-1:0]  lines [num_sets][num_ways];
    logic [line_bits-1:0]  hit_line;
    logic [index_bits-1:0] idx;

    assign idx = look_addr.f.index;
    assign hit_line = lines[idx][hit_way];
    // Old contents, read before the fill edge
    assign victim_line = lines[idx][victim_way];

    // Byte merge shows the written line in the same cycle
    always_comb begin
        for (int b = 0; b < line_bytes; b++) begin
            if (data_we && req_mask[b]) begin
                read_line[b*8 +: 8] = req_data[b*8 +: 8];
            end else begin
                read_line[b*8 +: 8] = hit_line[b*8 +: 8];
            end
        end
    end

    // No stores while reset is held
    always_ff @(posedge clk) begin
        if (!reset) begin
            if (fill_we) begin
                lines[idx][victim_way] <= fill_line;
            end else if (data_we) begin
                lines[idx][hit_way] <= read_line;
            end
        end
    end

endmodule

//--- src/cache_meta_store.sv
`timescale 1ns/1ps

module cache_meta_store
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  phys_addr_t          look_addr,
    input  logic [num_ways-1:0] valid_vec,
    input  logic                touch,
    input  way_t                hit_way,
    input  logic                data_we,
    input  logic                fill_we,
    output way_t                victim_way,
    output logic                victim_dirty
);

    // Age 0 is the most recently used way
    way_t                  ages  [num_sets][num_ways];
    logic [num_ways-1:0]   dirty [num_sets];
    logic [index_bits-1:0] idx;
    logic [num_sets-1:0]   ages_perm;

    assign idx = look_addr.f.index;
    assign victim_dirty = dirty[idx][victim_way];

    // Lowest invalid way wins over the oldest way
    always_comb begin
        victim_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (ages[idx][w] == way_t'(num_ways - 1)) begin
                victim_way = way_t'(w);
            end
        end
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_vec[w]) begin
                victim_way = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                dirty[s] <= '0;
                for (int w = 0; w < num_ways; w++) begin
                    ages[s][w] <= way_t'(w);
                end
            end
        end else begin
            if (touch) begin
                for (int w = 0; w < num_ways; w++) begin
                    if (way_t'(w) == hit_way) begin
                        ages[idx][w] <= '0;
                    end else if (ages[idx][w] < ages[idx][hit_way]) begin
                        ages[idx][w] <= ages[idx][w] + 1'b1;
                    end
                end
            end
            // A fresh line is clean
            if (fill_we) begin
                dirty[idx][victim_way] <= 1'b0;
            end else if (data_we) begin
                dirty[idx][hit_way] <= 1'b1;
            end
        end
    end

    always_comb begin
        logic [num_ways-1:0] seen;
        for (int s = 0; s < num_sets; s++) begin
            seen = '0;
            for (int w = 0; w < num_ways; w++) begin
                seen[ages[s][w]] = 1'b1;
            end
            ages_perm[s] = &seen;
        end
    end

    a_ages_perm: assert property (@(posedge clk) disable iff (reset) &ages_perm);

endmodule

//--- src/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  phys_addr_t          look_addr,
    input  logic                fill_we,
    input  way_t                victim_way,
    output hit_vec_t            hit_vec,
    output logic [tag_bits-1:0] victim_tag,
    output logic [num_ways-1:0] valid_vec
);

    logic [tag_bits-1:0]   tags  [num_sets][num_ways];
    logic [num_ways-1:0]   valid [num_sets];
    logic [index_bits-1:0] idx;

    assign idx = look_addr.f.index;
    assign valid_vec = valid[idx];
    assign victim_tag = tags[idx][victim_way];

    // Four-way compare against the looked-up set
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w] = valid[idx][w] && (tags[idx][w] == look_addr.f.tag);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_we) begin
            valid[idx][victim_way] <= 1'b1;
        end
    end

    // Tag install into the victim way
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tags[idx][victim_way] <= look_addr.f.tag;
        end
    end

endmodule

//--- src/cache_pkg.sv
package cache_pkg;

    // Cache geometry
    localparam int num_sets    = 4;
    localparam int num_ways    = 4;
    localparam int line_bytes  = 16;
    localparam int line_bits   = line_bytes * 8;

    // Physical address split
    localparam int addr_bits   = 15;
    localparam int tag_bits    = 8;
    localparam int index_bits  = 2;
    localparam int offset_bits = 5;

    // Depth of the miss handler request queue
    localparam int miss_credits = 2;
    localparam int credit_bits  = $clog2(miss_credits + 1);

    typedef logic [1:0]          way_t;
    typedef logic [num_ways-1:0] hit_vec_t;

    // Only the low 4 offset bits select a byte
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [addr_bits-1:0] raw;
        addr_fields_t         f;
    } phys_addr_t;

endpackage
